// File: tama_core.f
hdl/tama_pkg.sv
hdl/clock_enable_gen.sv
hdl/program_rom.sv
hdl/level_sync.sv
hdl/download_router.sv
hdl/tama_core_top.sv
tests/tb_tama_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the glue-logic testbench with verilator and runs it
# the result is read from the simulation log

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing \
  --top-module tb_tama_core \
  -Mdir "$build_dir" \
  -f tama_core.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/Vtb_tama_core" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Checks failed" "$log_file"; then
  echo "simulation reported failures"
  exit 1
fi

echo "simulation passed"
exit 0

// File: tests/tb_tama_core.sv
// directed testbench for the virtual-pet glue logic top level
// runs timebase, rom load, image routing and input sync tests in turn
// inputs change on the rising edge, outputs are sampled on the falling edge

`timescale 1ns/1ps

module tb_tama_core;

  import tama_pkg::*;

  // tests take about 2250 cycles with 2000 of them timebase
  localparam int timeout_cycles  = 4000;
  localparam int timebase_cycles = 2000;
  localparam int n_words         = 16;
  localparam int n_key_changes   = 8;
  // clk_en spacing and the offset of each midpoint 2x pulse
  localparam int clk_en_period   = 401;
  localparam int clk_2x_offset   = 201;

  logic        clk_32_768;
  logic        reset;
  logic        load_write_en;
  load_addr_t  load_addr;
  load_data_t  load_data;
  slot_id_t    slot_id;
  rom_addr_t   rom_addr;
  key_t        cont1_key;
  logic        core_run;
  rom_data_t   rom_data;
  logic        clk_en;
  logic        clk_2x_en;
  logic        background_write_en;
  logic        spritesheet_write_en;
  image_addr_t image_write_addr;
  load_data_t  image_write_data;
  k0_t         input_k0;
  logic        cpu_run;

  int          errors;
  int          cycle_count;
  logic [31:0] rng_state;
  // byte addresses of the rom test reused by the image tests
  load_addr_t  word_addrs [n_words];
  rom_data_t   rom_expect [n_words];

  tama_core_top dut (.*);

  initial begin
    clk_32_768 = 1'b0;
    forever #5 clk_32_768 = ~clk_32_768;
  end

  // run limit
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk_32_768);
      cycle_count = cycle_count + 1;
    end
    $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
    $display("Checks failed");
    $finish;
  end

  ////////////////////////////////////////
  // helpers

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // face keys are active low on k0 with bit 3 unused
  function automatic k0_t expected_k0(input key_t key);
    k0_t k0;
    k0    = '0;
    k0[0] = !key[key_face_a];
    k0[1] = !key[key_face_b];
    k0[2] = !key[key_face_y];
    return k0;
  endfunction

  task automatic compare_rom_data(input string name, input rom_data_t expected, actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_image_addr(input string name, input image_addr_t expected, actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_load_data(input string name, input load_data_t expected, actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_k0(input string name, input k0_t expected, actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, actual);
    if (actual !== expected) begin
      errors++;
      $display("mismatch %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // call right after a rising edge
  task automatic present_load(input load_addr_t addr, input load_data_t data);
    load_write_en <= 1'b1;
    load_addr     <= addr;
    load_data     <= data;
  endtask

  task automatic check_quiet(input string name);
    compare_bit({name, " background_write_en"}, 1'b0, background_write_en);
    compare_bit({name, " spritesheet_write_en"}, 1'b0, spritesheet_write_en);
  endtask

  // one cycle read latency
  task automatic verify_rom(input string name);
    int i;
    for (i = 0; i < n_words; i++) begin
      @(posedge clk_32_768);
      rom_addr <= word_addrs[i][13:1];
      @(posedge clk_32_768);
      @(negedge clk_32_768);
      compare_rom_data($sformatf("%s word %0d", name, i), rom_expect[i], rom_data);
    end
  endtask

  ////////////////////////////////////////
  // tests

  // n counts rising edges since reset release
  // the midpoint 2x pulse also comes in the first period
  task automatic run_timebase();
    int   n;
    logic en_expect;
    logic x2_expect;
    for (n = 1; n <= timebase_cycles; n++) begin
      @(posedge clk_32_768);
      @(negedge clk_32_768);
      en_expect = (n >= clk_en_period) && ((n % clk_en_period) == 0);
      x2_expect = en_expect || ((n >= clk_2x_offset) &&
                  (((n - clk_2x_offset) % clk_en_period) == 0));
      compare_bit($sformatf("timebase clk_en cycle %0d", n), en_expect, clk_en);
      compare_bit($sformatf("timebase clk_2x_en cycle %0d", n), x2_expect, clk_2x_en);
    end
  endtask

  task automatic load_and_read_rom();
    int         i;
    rom_addr_t  word;
    load_data_t data;
    rom_word_t  swapped;
    @(posedge clk_32_768);
    slot_id <= slot_rom;
    for (i = 0; i < n_words; i++) begin
      rng_state = xorshift32(rng_state);
      // low 4 bits keep the word addresses distinct
      word      = {rng_state[27:19], 4'(i)};
      word_addrs[i] = {rng_state[6:0], word, 1'b0};
      rng_state = xorshift32(rng_state);
      data      = rng_state[15:0];
      swapped   = {data[7:0], data[15:8]};
      rom_expect[i] = swapped[11:0];
      @(posedge clk_32_768);
      present_load(word_addrs[i], data);
      @(posedge clk_32_768);
      load_write_en <= 1'b0;
    end
    verify_rom("rom readback");
  endtask

  // strobes 2 cycles apart with one write each
  task automatic route_background();
    int         i;
    load_data_t data;
    @(posedge clk_32_768);
    slot_id <= slot_background;
    for (i = 0; i < n_words; i++) begin
      rng_state = xorshift32(rng_state);
      data      = rng_state[15:0];
      @(posedge clk_32_768);
      present_load(word_addrs[i], data);
      @(negedge clk_32_768);
      check_quiet("background idle");
      @(posedge clk_32_768);
      load_write_en <= 1'b0;
      @(negedge clk_32_768);
      compare_bit("background write_en", 1'b1, background_write_en);
      compare_bit("background sprite_en", 1'b0, spritesheet_write_en);
      compare_image_addr("background addr", word_addrs[i][17:1], image_write_addr);
      compare_load_data("background data", {data[7:0], data[15:8]}, image_write_data);
    end
    @(posedge clk_32_768);
    @(negedge clk_32_768);
    check_quiet("background end");
  endtask

  // strobes 3 cycles apart give the raw word then the high byte
  task automatic split_spritesheet();
    int         i;
    load_data_t data;
    @(posedge clk_32_768);
    slot_id <= slot_spritesheet;
    for (i = 0; i < n_words; i++) begin
      rng_state = xorshift32(rng_state);
      data      = rng_state[15:0];
      @(posedge clk_32_768);
      present_load(word_addrs[i], data);
      @(negedge clk_32_768);
      check_quiet("spritesheet idle");
      @(posedge clk_32_768);
      load_write_en <= 1'b0;
      @(negedge clk_32_768);
      compare_bit("spritesheet first en", 1'b1, spritesheet_write_en);
      compare_bit("spritesheet first bg", 1'b0, background_write_en);
      compare_image_addr("spritesheet first addr", word_addrs[i][16:0], image_write_addr);
      compare_load_data("spritesheet first data", data, image_write_data);
      @(posedge clk_32_768);
      @(negedge clk_32_768);
      compare_bit("spritesheet second en", 1'b1, spritesheet_write_en);
      compare_bit("spritesheet second bg", 1'b0, background_write_en);
      compare_image_addr("spritesheet second addr", word_addrs[i][16:0] + 17'd1,
                         image_write_addr);
      compare_load_data("spritesheet second data", {8'h00, data[15:8]}, image_write_data);
    end
    @(posedge clk_32_768);
    @(negedge clk_32_768);
    check_quiet("spritesheet end");
  endtask

  // old values for two cycles, new ones on the third
  task automatic sync_inputs();
    int   i;
    int   k;
    key_t key_old;
    key_t key_new;
    logic run_old;
    logic run_new;
    key_old = cont1_key;
    run_old = core_run;
    for (i = 0; i < n_key_changes; i++) begin
      rng_state = xorshift32(rng_state);
      key_new   = rng_state[15:0];
      if (expected_k0(key_new) == expected_k0(key_old)) begin
        key_new[key_face_a] = !key_new[key_face_a];
      end
      run_new = !run_old;
      @(posedge clk_32_768);
      cont1_key <= key_new;
      core_run  <= run_new;
      for (k = 1; k <= 3; k++) begin
        @(posedge clk_32_768);
        @(negedge clk_32_768);
        if (k < 3) begin
          compare_k0($sformatf("sync k0 held cycle %0d", k), expected_k0(key_old), input_k0);
          compare_bit($sformatf("sync run held cycle %0d", k), run_old, cpu_run);
        end else begin
          compare_k0("sync k0 updated", expected_k0(key_new), input_k0);
          compare_bit("sync run updated", run_new, cpu_run);
        end
      end
      key_old = key_new;
      run_old = run_new;
    end
  endtask

  ////////////////////////////////////////
  // main sequence

  initial begin
    errors        = 0;
    rng_state     = 32'h1f42;
    reset         <= 1'b1;
    load_write_en <= 1'b0;
    load_addr     <= '0;
    load_data     <= '0;
    slot_id       <= slot_rom;
    rom_addr      <= '0;
    cont1_key     <= '0;
    core_run      <= 1'b0;
    repeat (8) @(posedge clk_32_768);
    reset <= 1'b0;
    run_timebase();
    load_and_read_rom();
    route_background();
    split_spritesheet();
    // image loads must not touch the rom
    verify_rom("rom after image loads");
    sync_inputs();
    $display("checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: hdl/tama_core_top.sv
// glue logic around the virtual-pet cpu, all in the 32.768 mhz domain
// takes the download stream, controller keys and host run level
// gives rom data, image writes, cpu strobes and synced cpu inputs

`timescale 1ns/1ps

module tama_core_top (
  input  logic                  clk_32_768,
  input  logic                  reset,

  // download stream, already in the core domain
  input  logic                  load_write_en,
  input  tama_pkg::load_addr_t  load_addr,
  input  tama_pkg::load_data_t  load_data,
  input  tama_pkg::slot_id_t    slot_id,

  // cpu side
  input  tama_pkg::rom_addr_t   rom_addr,
  output tama_pkg::rom_data_t   rom_data,
  output logic                  clk_en,
  output logic                  clk_2x_en,
  output tama_pkg::k0_t         input_k0,
  output logic                  cpu_run,

  // image memory writes
  output logic                  background_write_en,
  output logic                  spritesheet_write_en,
  output tama_pkg::image_addr_t image_write_addr,
  output tama_pkg::load_data_t  image_write_data,

  // host side levels
  input  tama_pkg::key_t        cont1_key,
  input  logic                  core_run
);

  import tama_pkg::*;

  ////////////////////////////////////////
  // downloads into rom and image memory

  logic      rom_write_en;
  rom_addr_t rom_write_addr;
  rom_word_t rom_write_data;

  download_router download_router (
    .clk_32_768          (clk_32_768),
    .reset               (reset),
    .load_write_en       (load_write_en),
    .load_addr           (load_addr),
    .load_data           (load_data),
    .slot_id             (slot_id),
    .rom_write_en        (rom_write_en),
    .rom_write_addr      (rom_write_addr),
    .rom_write_data      (rom_write_data),
    .background_write_en (background_write_en),
    .spritesheet_write_en(spritesheet_write_en),
    .image_write_addr    (image_write_addr),
    .image_write_data    (image_write_data)
  );

  program_rom program_rom (
    .clk_32_768    (clk_32_768),
    .rom_write_en  (rom_write_en),
    .rom_write_addr(rom_write_addr),
    .rom_write_data(rom_write_data),
    .rom_addr      (rom_addr),
    .rom_data      (rom_data)
  );

  // cpu timebase
  clock_enable_gen clock_enable_gen (
    .clk_32_768(clk_32_768),
    .reset     (reset),
    .clk_en    (clk_en),
    .clk_2x_en (clk_2x_en)
  );

  ////////////////////////////////////////
  // input synchronizers

  key_t cont1_key_s;

  level_sync #(.sync_t(key_t)) key_sync (
    .clk_32_768(clk_32_768),
    .reset     (reset),
    .async_in  (cont1_key),
    .sync_out  (cont1_key_s)
  );

  level_sync #(.sync_t(logic)) run_sync (
    .clk_32_768(clk_32_768),
    .reset     (reset),
    .async_in  (core_run),
    .sync_out  (cpu_run)
  );

  // k0 buttons are active low
  assign input_k0 = {1'b0, ~cont1_key_s[key_face_y], ~cont1_key_s[key_face_b],
                     ~cont1_key_s[key_face_a]};

endmodule

// File: hdl/download_router.sv
// steers download words to the program rom or the image memories
// slot id picks the target, rom and background get byte-swapped words
// a spritesheet word becomes two writes, raw word then its high byte

`timescale 1ns/1ps

module download_router (
  input  logic                  clk_32_768,
  input  logic                  reset,
  input  logic                  load_write_en,
  input  tama_pkg::load_addr_t  load_addr,
  input  tama_pkg::load_data_t  load_data,
  input  tama_pkg::slot_id_t    slot_id,
  output logic                  rom_write_en,
  output tama_pkg::rom_addr_t   rom_write_addr,
  output tama_pkg::rom_word_t   rom_write_data,
  output logic                  background_write_en,
  output logic                  spritesheet_write_en,
  output tama_pkg::image_addr_t image_write_addr,
  output tama_pkg::load_data_t  image_write_data
);

  import tama_pkg::*;

  ////////////////////////////////////////
  // slot decode

  logic rom_download;
  logic background_download;
  logic spritesheet_download;

  assign rom_download         = (slot_id == slot_rom);
  assign background_download  = (slot_id == slot_background);
  assign spritesheet_download = (slot_id == slot_spritesheet);

  // loader sends big-endian words
  load_data_t load_data_swapped;
  assign load_data_swapped = {load_data[7:0], load_data[15:8]};

  // second spritesheet write due next cycle
  logic       sprite_pending;
  logic [7:0] sprite_high;

  ////////////////////////////////////////
  // write enables

  always_ff @(posedge clk_32_768) begin
    if (reset) begin
      rom_write_en         <= 1'b0;
      background_write_en  <= 1'b0;
      spritesheet_write_en <= 1'b0;
      sprite_pending       <= 1'b0;
    end else begin
      rom_write_en         <= load_write_en && rom_download;
      background_write_en  <= load_write_en && background_download;
      // raw word now, high byte on the following cycle
      spritesheet_write_en <= (load_write_en && spritesheet_download) || sprite_pending;
      sprite_pending       <= load_write_en && spritesheet_download;
    end
  end

  ////////////////////////////////////////
  // addresses and data

  always_ff @(posedge clk_32_768) begin
    if (load_write_en) begin
      // rom is word addressed
      rom_write_addr <= load_addr[13:1];
      rom_write_data <= load_data_swapped;
      sprite_high    <= load_data[15:8];
    end
    if (sprite_pending) begin
      // follow-up write at the next pixel address
      image_write_addr <= image_write_addr + 17'd1;
      image_write_data <= {8'h00, sprite_high};
    end else if (load_write_en) begin
      if (spritesheet_download) begin
        // spritesheet keeps byte addressing and raw data
        image_write_addr <= load_addr[16:0];
        image_write_data <= load_data;
      end else begin
        image_write_addr <= load_addr[17:1];
        image_write_data <= load_data_swapped;
      end
    end
  end

endmodule

// File: hdl/level_sync.sv
// three-stage synchronizer for levels entering the core domain
// payload type is a parameter, used for key bitmaps and single bits
// output follows the input three cycles later

`timescale 1ns/1ps

module level_sync #(
  parameter type sync_t = logic
) (
  input  logic  clk_32_768,
  input  logic  reset,
  input  sync_t async_in,
  output sync_t sync_out
);

  // first two flops of the chain
  sync_t stage_1;
  sync_t stage_2;

  always_ff @(posedge clk_32_768) begin
    if (reset) begin
      stage_1  <= '0;
      stage_2  <= '0;
      sync_out <= '0;
    end else begin
      stage_1  <= async_in;
      stage_2  <= stage_1;
      sync_out <= stage_2;
    end
  end

endmodule

// File: hdl/program_rom.sv
// program memory for the cpu, filled only by downloads
// one write port from the download router, one registered read port
// read data is the low 12 bits of the stored word, one cycle late

`timescale 1ns/1ps

module program_rom (
  input  logic                clk_32_768,
  input  logic                rom_write_en,
  input  tama_pkg::rom_addr_t rom_write_addr,
  input  tama_pkg::rom_word_t rom_write_data,
  input  tama_pkg::rom_addr_t rom_addr,
  output tama_pkg::rom_data_t rom_data
);

  import tama_pkg::*;

  // full 16 bit words as loaded
  rom_word_t rom_mem [rom_words];

  ////////////////////////////////////////
  // write port

  always_ff @(posedge clk_32_768) begin
    if (rom_write_en) begin
      rom_mem[rom_write_addr] <= rom_write_data;
    end
  end

  ////////////////////////////////////////
  // read port

  // keep only the instruction bits
  always_ff @(posedge clk_32_768) begin
    rom_data <= rom_data_t'(rom_mem[rom_addr]);
  end

endmodule

// File: hdl/clock_enable_gen.sv
// cpu clock-enable strobes for the 32.768 mhz core domain
// clk_en is the 1x cpu strobe, clk_2x_en fires at twice that rate
// both are single-cycle pulses taken from one down-counter

`timescale 1ns/1ps

module clock_enable_gen (
  input  logic clk_32_768,
  input  logic reset,
  output logic clk_en,
  output logic clk_2x_en
);

  import tama_pkg::*;

  // midpoint of the count gives the extra 2x pulse
  localparam logic [9:0] half_count = clk_div_count / 2;

  logic [9:0] clock_div;

  always_ff @(posedge clk_32_768) begin
    if (reset) begin
      clock_div <= clk_div_count;
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
    end else begin
      // no strobe by default while counting down
      clk_en    <= 1'b0;
      clk_2x_en <= 1'b0;
      clock_div <= clock_div - 10'd1;
      if (clock_div == 10'd0) begin
        // wrap with both strobes together
        clock_div <= clk_div_count;
        clk_en    <= 1'b1;
        clk_2x_en <= 1'b1;
      end else if (clock_div == half_count) begin
        clk_2x_en <= 1'b1;
      end
    end
  end

endmodule

// File: hdl/tama_pkg.sv
// shared widths, types and constants for the virtual-pet glue logic
// every block pulls its port types and constants from here

package tama_pkg;

  ////////////////////////////////////////
  // timebase

  // cpu strobe divider reload from 32.768 mhz down to the cpu rate
  localparam logic [9:0] clk_div_count = 10'd400;

  ////////////////////////////////////////
  // program rom

  localparam int rom_words = 8192;

  typedef logic [12:0] rom_addr_t;
  // stored word, as swapped on download
  typedef logic [15:0] rom_word_t;
  // instruction bits seen by the cpu
  typedef logic [11:0] rom_data_t;

  ////////////////////////////////////////
  // download stream

  // byte address from the loader
  typedef logic [20:0] load_addr_t;
  typedef logic [15:0] load_data_t;
  typedef logic [15:0] slot_id_t;

  // slot ids from the host data table
  localparam slot_id_t slot_rom         = 16'd0;
  localparam slot_id_t slot_background  = 16'd10;
  localparam slot_id_t slot_spritesheet = 16'd11;

  // image memory write address
  typedef logic [16:0] image_addr_t;

  ////////////////////////////////////////
  // controller inputs

  typedef logic [15:0] key_t;
  // face button positions in the key bitmap
  localparam int key_face_a = 4;
  localparam int key_face_b = 5;
  localparam int key_face_y = 7;

  typedef logic [3:0] k0_t;

endpackage
